// File: Bender.yml
package:
  name: mem_subsys

sources:
  - mem_pkg.sv
  - data_sram.sv
  - mem_stage.sv
  - mem_bridge.sv
  - mem_subsys_top.sv
  - target: simulation
    files:
      - mem_subsys_asserts.sv
      - tb_mem_subsys.sv

// File: all.f
mem_pkg.sv
data_sram.sv
mem_stage.sv
mem_bridge.sv
mem_subsys_top.sv
mem_subsys_asserts.sv
tb_mem_subsys.sv

// File: data_sram.sv
// single-port synchronous data memory with byte write mask
`timescale 1ns/100ps
`default_nettype none

module data_sram (
  input  wire                 clk,
  input  wire                 en_i,
  input  wire                 we_i,
  input  wire mem_pkg::widx_t idx_i,
  input  wire mem_pkg::strb_t strb_i,
  input  wire mem_pkg::word_t wdata_i,
  output mem_pkg::word_t      rdata_o
);

  mem_pkg::word_t mem [mem_pkg::MEM_WORDS];
  mem_pkg::word_t rdata_q;

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < mem_pkg::STRB_W; b++) begin
          if (strb_i[b]) begin
            mem[idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem[idx_i];  // ready next cycle
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: mem_bridge.sv
// bridge from write/read channels to the single-port data memory
`timescale 1ns/100ps
`default_nettype none

module mem_bridge (
  input  wire                   clk,
  input  wire                   reset_i,
  input  wire                   wr_valid_i,
  output logic                  wr_ready_o,
  input  wire mem_pkg::wr_req_t wr_req_i,
  output logic                  wr_resp_valid_o,
  input  wire                   wr_resp_ready_i,
  input  wire                   rd_valid_i,
  output logic                  rd_ready_o,
  input  wire mem_pkg::rd_req_t rd_req_i,
  output logic                  rd_resp_valid_o,
  input  wire                   rd_resp_ready_i,
  output mem_pkg::word_t        rd_resp_data_o,
  output logic                  mem_en_o,
  output logic                  mem_we_o,
  output mem_pkg::widx_t        mem_idx_o,
  output mem_pkg::strb_t        mem_strb_o,
  output mem_pkg::word_t        mem_wdata_o,
  input  wire mem_pkg::word_t   mem_rdata_i
);

  mem_pkg::bridge_state_t state_q;
  logic                   op_wr_q;
  logic                   rd_valid_q;
  mem_pkg::widx_t         idx_q;
  mem_pkg::strb_t         strb_q;
  mem_pkg::word_t         data_q;
  mem_pkg::word_t         rd_data_q;

  // write wins when both are pending
  assign wr_ready_o = (state_q == mem_pkg::BR_IDLE) && wr_valid_i;
  assign rd_ready_o = (state_q == mem_pkg::BR_IDLE) && rd_valid_i && !wr_valid_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q    <= mem_pkg::BR_IDLE;
      op_wr_q    <= 1'b0;
      rd_valid_q <= 1'b0;
    end else begin
      case (state_q)
        mem_pkg::BR_IDLE: begin
          if (wr_ready_o) begin
            state_q <= mem_pkg::BR_WRITE;
            op_wr_q <= 1'b1;
          end else if (rd_ready_o) begin
            state_q <= mem_pkg::BR_READ;
            op_wr_q <= 1'b0;
          end
        end
        mem_pkg::BR_WRITE: state_q <= mem_pkg::BR_RESP;
        mem_pkg::BR_READ:  state_q <= mem_pkg::BR_RESP;
        mem_pkg::BR_RESP: begin
          if (op_wr_q) begin
            if (wr_resp_ready_i) state_q <= mem_pkg::BR_IDLE;
          end else if (!rd_valid_q) begin
            rd_valid_q <= 1'b1;  // word from sram is out now
          end else if (rd_resp_ready_i) begin
            rd_valid_q <= 1'b0;
            state_q    <= mem_pkg::BR_IDLE;
          end
        end
        default: state_q <= mem_pkg::BR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ready_o) begin
      idx_q  <= wr_req_i.addr[3 +: mem_pkg::WIDX_W];
      strb_q <= wr_req_i.strb;
      data_q <= wr_req_i.data;
    end else if (rd_ready_o) begin
      idx_q <= rd_req_i.addr[3 +: mem_pkg::WIDX_W];
    end
    if (state_q == mem_pkg::BR_RESP && !op_wr_q && !rd_valid_q) begin
      rd_data_q <= mem_rdata_i;
    end
  end

  assign mem_en_o    = (state_q == mem_pkg::BR_WRITE) || (state_q == mem_pkg::BR_READ);
  assign mem_we_o    = (state_q == mem_pkg::BR_WRITE);
  assign mem_idx_o   = idx_q;
  assign mem_strb_o  = strb_q;
  assign mem_wdata_o = data_q;

  assign wr_resp_valid_o = (state_q == mem_pkg::BR_RESP) && op_wr_q;
  assign rd_resp_valid_o = rd_valid_q;
  assign rd_resp_data_o  = rd_data_q;

endmodule

`default_nettype wire

// File: mem_pkg.sv
// widths, vector types, core request and channel structs, fsm state enums
`default_nettype none

package mem_pkg;

  localparam int XLEN      = 64;
  localparam int MEM_WORDS = 512;
  localparam int STRB_W    = XLEN / 8;
  localparam int WIDX_W    = $clog2(MEM_WORDS);

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [XLEN-1:0]   addr_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [WIDX_W-1:0] widx_t;
  typedef logic [1:0]        acc_size_t;

  // access size codes
  localparam acc_size_t SIZE_B = 2'd0;
  localparam acc_size_t SIZE_H = 2'd1;
  localparam acc_size_t SIZE_W = 2'd2;
  localparam acc_size_t SIZE_D = 2'd3;

  typedef struct packed {
    logic      load;
    logic      store;
    addr_t     addr;
    word_t     wdata;  // low bits of rs2
    acc_size_t size;
    logic      sext;
  } mem_req_t;

  typedef struct packed {
    addr_t addr;
    word_t data;
    strb_t strb;
  } wr_req_t;

  typedef struct packed {
    addr_t addr;
  } rd_req_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_REQ,
    ST_WR_RESP,
    ST_RD_REQ,
    ST_RD_RESP
  } stage_state_t;

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_WRITE,
    BR_READ,
    BR_RESP
  } bridge_state_t;

endpackage

`default_nettype wire

// File: mem_stage.sv
// memory stage with lane alignment, write and read request channels, load extension
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
  input  wire                    clk,
  input  wire                    reset_i,
  input  wire mem_pkg::mem_req_t req_i,
  output logic                   wr_valid_o,
  input  wire                    wr_ready_i,
  output mem_pkg::wr_req_t       wr_req_o,
  input  wire                    wr_resp_valid_i,
  output logic                   wr_resp_ready_o,
  output logic                   rd_valid_o,
  input  wire                    rd_ready_i,
  output mem_pkg::rd_req_t       rd_req_o,
  input  wire                    rd_resp_valid_i,
  output logic                   rd_resp_ready_o,
  input  wire mem_pkg::word_t    rd_resp_data_i,
  output logic                   busy_o,
  output logic                   done_o,
  output mem_pkg::word_t         rdata_o
);

  mem_pkg::stage_state_t state_q;
  mem_pkg::addr_t        addr_q;
  mem_pkg::word_t        wdata_q;
  mem_pkg::strb_t        strb_q;
  mem_pkg::acc_size_t    size_q;
  logic                  sext_q;
  logic                  done_q;
  mem_pkg::word_t        rdata_q;
  mem_pkg::strb_t        size_mask;
  mem_pkg::word_t        shifted;
  mem_pkg::word_t        ext_data;
  logic [2:0]            req_off;
  logic                  strobe;

  assign req_off = req_i.addr[2:0];
  assign strobe  = (state_q == mem_pkg::ST_IDLE) && (req_i.load || req_i.store);

  always_comb begin
    size_mask = 8'hff;
    case (req_i.size)
      mem_pkg::SIZE_B: size_mask = 8'h01;
      mem_pkg::SIZE_H: size_mask = 8'h03;
      mem_pkg::SIZE_W: size_mask = 8'h0f;
      mem_pkg::SIZE_D: size_mask = 8'hff;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= mem_pkg::ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        mem_pkg::ST_IDLE: begin
          if (req_i.store) begin
            state_q <= mem_pkg::ST_WR_REQ;
          end else if (req_i.load) begin
            state_q <= mem_pkg::ST_RD_REQ;
          end
        end
        mem_pkg::ST_WR_REQ:  if (wr_ready_i) state_q <= mem_pkg::ST_WR_RESP;
        mem_pkg::ST_RD_REQ:  if (rd_ready_i) state_q <= mem_pkg::ST_RD_RESP;
        mem_pkg::ST_WR_RESP: begin
          if (wr_resp_valid_i) begin
            state_q <= mem_pkg::ST_IDLE;
            done_q  <= 1'b1;
          end
        end
        mem_pkg::ST_RD_RESP: begin
          if (rd_resp_valid_i) begin
            state_q <= mem_pkg::ST_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= mem_pkg::ST_IDLE;
      endcase
    end
  end

  // payload captured once per access
  always_ff @(posedge clk) begin
    if (strobe) begin
      addr_q  <= req_i.addr;
      wdata_q <= req_i.wdata << {req_off, 3'b000};
      strb_q  <= size_mask << req_off;
      size_q  <= req_i.size;
      sext_q  <= req_i.sext;
    end
    if (state_q == mem_pkg::ST_RD_RESP && rd_resp_valid_i) begin
      rdata_q <= ext_data;  // same edge as done
    end
  end

  // move addressed field down, then extend
  always_comb begin
    shifted  = rd_resp_data_i >> {addr_q[2:0], 3'b000};
    ext_data = shifted;
    case (size_q)
      mem_pkg::SIZE_B: ext_data = {{(mem_pkg::XLEN-8){sext_q & shifted[7]}}, shifted[7:0]};
      mem_pkg::SIZE_H: ext_data = {{(mem_pkg::XLEN-16){sext_q & shifted[15]}}, shifted[15:0]};
      mem_pkg::SIZE_W: ext_data = {{(mem_pkg::XLEN-32){sext_q & shifted[31]}}, shifted[31:0]};
      mem_pkg::SIZE_D: ext_data = shifted;
    endcase
  end

  assign wr_valid_o      = (state_q == mem_pkg::ST_WR_REQ);
  assign wr_req_o        = mem_pkg::wr_req_t'{addr: addr_q, data: wdata_q, strb: strb_q};
  assign wr_resp_ready_o = (state_q == mem_pkg::ST_WR_RESP);
  assign rd_valid_o      = (state_q == mem_pkg::ST_RD_REQ);
  assign rd_req_o        = mem_pkg::rd_req_t'{addr: addr_q};
  assign rd_resp_ready_o = (state_q == mem_pkg::ST_RD_RESP);
  assign busy_o          = (state_q != mem_pkg::ST_IDLE);
  assign done_o          = done_q;
  assign rdata_o         = rdata_q;

endmodule

`default_nettype wire

// File: mem_subsys_asserts.sv
// handshake, stall, alignment and reset assertions, bound to the subsystem top
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_asserts (
  input wire                    clk,
  input wire                    reset_i,
  input wire mem_pkg::mem_req_t req_i,
  input wire                    busy_o,
  input wire                    done_o,
  input wire                    wr_valid,
  input wire                    wr_ready,
  input wire mem_pkg::wr_req_t  wr_req,
  input wire                    wr_resp_valid,
  input wire                    wr_resp_ready,
  input wire                    rd_valid,
  input wire                    rd_ready,
  input wire mem_pkg::rd_req_t  rd_req,
  input wire                    rd_resp_valid,
  input wire                    rd_resp_ready,
  input wire mem_pkg::word_t    rd_resp_data
);

  int   err_count = 0;
  logic strobe;

  assign strobe = req_i.load || req_i.store;

  wr_req_hold: assert property (@(posedge clk) disable iff (reset_i)
    wr_valid && !wr_ready |=> wr_valid && $stable(wr_req))
    else begin
      err_count++;
      $error("write request dropped or changed before ready");
    end
  rd_req_hold: assert property (@(posedge clk) disable iff (reset_i)
    rd_valid && !rd_ready |=> rd_valid && $stable(rd_req))
    else begin
      err_count++;
      $error("read request dropped or changed before ready");
    end
  wr_resp_hold: assert property (@(posedge clk) disable iff (reset_i)
    wr_resp_valid && !wr_resp_ready |=> wr_resp_valid)
    else begin
      err_count++;
      $error("write response dropped before ready");
    end
  rd_resp_hold: assert property (@(posedge clk) disable iff (reset_i)
    rd_resp_valid && !rd_resp_ready |=> rd_resp_valid && $stable(rd_resp_data))
    else begin
      err_count++;
      $error("read response dropped or changed before ready");
    end

  no_strobe_busy: assert property (@(posedge clk) disable iff (reset_i)
    strobe |-> !busy_o && !(req_i.load && req_i.store))
    else begin
      err_count++;
      $error("strobe while busy, or load and store together");
    end
  busy_after_strobe: assert property (@(posedge clk) disable iff (reset_i) strobe |=> busy_o)
    else begin
      err_count++;
      $error("busy did not rise after strobe");
    end
  // done exactly where busy drops
  busy_ends_done: assert property (@(posedge clk) disable iff (reset_i)
    $fell(busy_o) == done_o)
    else begin
      err_count++;
      $error("busy fell without done, or done without busy falling");
    end
  done_pulse: assert property (@(posedge clk) disable iff (reset_i) done_o |=> !done_o)
    else begin
      err_count++;
      $error("done held longer than one cycle");
    end
  aligned: assert property (@(posedge clk) disable iff (reset_i)
    strobe |-> (req_i.addr[2:0] & ~(3'b111 << req_i.size)) == 3'b000)
    else begin
      err_count++;
      $error("misaligned access");
    end

  reset_quiet: assert property (@(posedge clk) reset_i |=>
    !busy_o && !done_o && !wr_valid && !rd_valid && !wr_ready && !rd_ready &&
    !wr_resp_valid && !rd_resp_valid && !wr_resp_ready && !rd_resp_ready)
    else begin
      err_count++;
      $error("outputs not low after reset");
    end

endmodule

bind mem_subsys_top mem_subsys_asserts i_asserts (
  .clk           (clk),
  .reset_i       (reset_i),
  .req_i         (req_i),
  .busy_o        (busy_o),
  .done_o        (done_o),
  .wr_valid      (wr_valid),
  .wr_ready      (wr_ready),
  .wr_req        (wr_req),
  .wr_resp_valid (wr_resp_valid),
  .wr_resp_ready (wr_resp_ready),
  .rd_valid      (rd_valid),
  .rd_ready      (rd_ready),
  .rd_req        (rd_req),
  .rd_resp_valid (rd_resp_valid),
  .rd_resp_ready (rd_resp_ready),
  .rd_resp_data  (rd_resp_data)
);

`default_nettype wire

// File: mem_subsys_top.sv
// memory subsystem top with stage, channel bridge and data memory
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_top (
  input  wire                    clk,
  input  wire                    reset_i,
  input  wire mem_pkg::mem_req_t req_i,
  output logic                   busy_o,
  output logic                   done_o,
  output mem_pkg::word_t         rdata_o
);

  logic             wr_valid;
  logic             wr_ready;
  mem_pkg::wr_req_t wr_req;
  logic             wr_resp_valid;
  logic             wr_resp_ready;
  logic             rd_valid;
  logic             rd_ready;
  mem_pkg::rd_req_t rd_req;
  logic             rd_resp_valid;
  logic             rd_resp_ready;
  mem_pkg::word_t   rd_resp_data;
  logic             mem_en;
  logic             mem_we;
  mem_pkg::widx_t   mem_idx;
  mem_pkg::strb_t   mem_strb;
  mem_pkg::word_t   mem_wdata;
  mem_pkg::word_t   mem_rdata;

  mem_stage i_stage (
    .clk             (clk),
    .reset_i         (reset_i),
    .req_i           (req_i),
    .wr_valid_o      (wr_valid),
    .wr_ready_i      (wr_ready),
    .wr_req_o        (wr_req),
    .wr_resp_valid_i (wr_resp_valid),
    .wr_resp_ready_o (wr_resp_ready),
    .rd_valid_o      (rd_valid),
    .rd_ready_i      (rd_ready),
    .rd_req_o        (rd_req),
    .rd_resp_valid_i (rd_resp_valid),
    .rd_resp_ready_o (rd_resp_ready),
    .rd_resp_data_i  (rd_resp_data),
    .busy_o          (busy_o),
    .done_o          (done_o),
    .rdata_o         (rdata_o)
  );

  mem_bridge i_bridge (
    .clk             (clk),
    .reset_i         (reset_i),
    .wr_valid_i      (wr_valid),
    .wr_ready_o      (wr_ready),
    .wr_req_i        (wr_req),
    .wr_resp_valid_o (wr_resp_valid),
    .wr_resp_ready_i (wr_resp_ready),
    .rd_valid_i      (rd_valid),
    .rd_ready_o      (rd_ready),
    .rd_req_i        (rd_req),
    .rd_resp_valid_o (rd_resp_valid),
    .rd_resp_ready_i (rd_resp_ready),
    .rd_resp_data_o  (rd_resp_data),
    .mem_en_o        (mem_en),
    .mem_we_o        (mem_we),
    .mem_idx_o       (mem_idx),
    .mem_strb_o      (mem_strb),
    .mem_wdata_o     (mem_wdata),
    .mem_rdata_i     (mem_rdata)
  );

  data_sram i_sram (
    .clk     (clk),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .idx_i   (mem_idx),
    .strb_i  (mem_strb),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

// File: tb_mem_subsys.sv
// testbench for the memory subsystem with directed and random loads and stores against a shadow memory
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys;

  localparam int CLK_PERIOD    = 40;
  localparam int SEED          = 6260;
  localparam int WIN_WORDS     = 32;
  localparam int RANDOM_REQS   = 200;
  localparam int DIRECTED_REQS = 15 * 4 + 1 + 14 * 2;
  localparam int TOTAL_REQS    = WIN_WORDS + DIRECTED_REQS + RANDOM_REQS;
  localparam int MAX_CYCLES    = TOTAL_REQS * 10 + 100;
  localparam mem_pkg::addr_t BASE = 64'h400;  // word 128

  logic              clk;
  logic              reset_i;
  mem_pkg::mem_req_t req;
  logic              busy;
  logic              done;
  mem_pkg::word_t    rdata;
  logic [7:0]        shadow [WIN_WORDS*8];  // byte copy of the window
  int                cycles = 0;

  mem_subsys_top i_dut (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (req),
    .busy_o  (busy),
    .done_o  (done),
    .rdata_o (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      stop_on_failure($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  // bound protocol checker counts its failures
  always @(negedge clk) begin
    if (i_dut.i_asserts.err_count != 0) stop_on_failure("a protocol assertion failed");
  end

  // fill pattern depending on every address bit
  function automatic mem_pkg::word_t fill_word(input mem_pkg::addr_t a);
    return (a * 64'h9e37_79b9_7f4a_7c15) ^ 64'h0123_4567_89ab_cdef;
  endfunction

  function automatic mem_pkg::word_t expected_load(input mem_pkg::addr_t a,
                                                   input mem_pkg::acc_size_t size,
                                                   input logic sext);
    int             nb;
    int             off;
    mem_pkg::word_t v;
    nb  = 1 << size;
    off = int'(a - BASE);
    v   = '0;
    for (int i = 0; i < nb; i++) begin
      v[8*i +: 8] = shadow[off+i];  // little endian
    end
    if (sext && v[8*nb-1]) begin
      for (int k = 8*nb; k < mem_pkg::XLEN; k++) v[k] = 1'b1;
    end
    return v;
  endfunction

  task automatic access(input logic is_store, input mem_pkg::addr_t a,
                        input mem_pkg::word_t wdata, input mem_pkg::acc_size_t size,
                        input logic sext);
    mem_pkg::word_t exp;
    int             nb;
    int             off;
    nb  = 1 << size;
    off = int'(a - BASE);
    exp = expected_load(a, size, sext);
    @(posedge clk);
    #2;
    req.load  = !is_store;
    req.store = is_store;
    req.addr  = a;
    req.wdata = wdata;
    req.size  = size;
    req.sext  = sext;
    @(posedge clk);
    #2;
    req = '0;  // one-cycle strobe
    while (!done) begin
      @(posedge clk);
      #2;
    end
    if (is_store) begin
      for (int i = 0; i < nb; i++) begin
        shadow[off+i] = wdata[8*i +: 8];
      end
    end else begin
      assert (rdata === exp) else stop_on_failure(
        $sformatf("error: rdata_o=%h expected=%h addr=%h", rdata, exp, a));
    end
  endtask

  initial begin
    mem_pkg::addr_t     a;
    mem_pkg::word_t     val;
    mem_pkg::acc_size_t sz;
    int                 nb;
    void'($urandom(SEED));
    req     = '0;
    reset_i = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    reset_i = 1'b0;

    for (int w = 0; w < WIN_WORDS; w++) begin
      a = BASE + 8*w;
      access(1'b1, a, fill_word(a), mem_pkg::SIZE_D, 1'b0);
    end

    // every size at every aligned offset with the top bit of the field set
    for (int s = 0; s < 4; s++) begin
      sz = mem_pkg::acc_size_t'(s);
      nb = 1 << s;
      for (int off = 0; off < 8; off += nb) begin
        a   = BASE + 40 + off;
        val = {$urandom, $urandom} | (64'd1 << (8*nb-1));
        access(1'b1, a, val, sz, 1'b0);
        access(1'b0, a, '0, sz, 1'b1);
        access(1'b0, a, '0, sz, 1'b0);
        access(1'b0, BASE + 40, '0, mem_pkg::SIZE_D, 1'b0);  // neighbours intact
      end
    end

    // one wide store, then narrow fields out of it
    access(1'b1, BASE + 72, 64'hf1e2_d3c4_b5a6_9788, mem_pkg::SIZE_D, 1'b0);
    for (int s = 0; s < 3; s++) begin
      sz = mem_pkg::acc_size_t'(s);
      for (int off = 0; off < 8; off += (1 << s)) begin
        access(1'b0, BASE + 72 + off, '0, sz, 1'b0);
        access(1'b0, BASE + 72 + off, '0, sz, 1'b1);
      end
    end

    repeat (RANDOM_REQS) begin
      sz  = mem_pkg::acc_size_t'($urandom_range(3, 0));
      a   = BASE + 8 * $urandom_range(WIN_WORDS-1, 0);
      a   = a + ($urandom_range(7, 0) & ~((1 << sz) - 1));
      val = {$urandom, $urandom};
      access(1'($urandom_range(1, 0)), a, val, sz, 1'($urandom_range(1, 0)));
    end

    if (i_dut.i_asserts.err_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      stop_on_failure("protocol assertions failed during the run");
    end
  end

endmodule

`default_nettype wire
